/* compile.f */
+incdir+.
uartPkg.sv
baudTimer.sv
txFsm.sv
txShifter.sv
txFifo.sv
apbUartRegs.sv
uartTx.sv
tbClock.sv
uartTx_checker.sv
tbUartTx.sv

/* run.sh */
#!/bin/sh
# Build and run the UART transmitter testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ns --top-module tbUartTx \
    -f compile.f -o simUartTx
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/simUartTx > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^PASS: all tests$" sim.log; then
    echo "Run passed"
    exit 0
fi
echo "Run failed"
exit 1

/* tbUartTx.sv */
`timescale 1ns/1ns
`default_nettype none
`include "uart_params.svh"

module tbUartTx;
    import uartPkg::*;

    localparam int RAND_BURSTS = 5;
    localparam int BURST_LEN   = 8;
    localparam int FULL_DIV    = 40;
    localparam int FULL_WRITES = 17;
    localparam int MAX_DIV     = 48;
    // Worst-case frames per test times (10 * divisor + 8), plus bus traffic.
    localparam int BUDGET = RAND_BURSTS * BURST_LEN * (10 * 9 + 8)
                          + (FULL_WRITES + 1) * (10 * FULL_DIV + 8)
                          + 6 * (10 * MAX_DIV + 8) + 4000;

    logic        clk;
    logic        rst;
    apbReq_t     apbReq;
    apbRsp_t     apbRsp;
    logic        txd;

    logic [31:0] rngState = 32'hf770;
    divisor_t    modelDiv = divisor_t'(234);
    txByte_t     expQ [$];
    int          accepted = 0;
    int          started = 0;
    logic        frameActive = 1'b0;
    int          dataErrs = 0;
    int          statusErrs = 0;
    int          divErrs = 0;
    int          busErrs = 0;
    int          lineErrs = 0;

    tbClock uClock (.clk(clk));

    uartTx u_uartTx (
        .clk    (clk),
        .rst    (rst),
        .apbReq (apbReq),
        .apbRsp (apbRsp),
        .txd    (txd)
    );

    bind uartTx uartTx_checker uChecker (
        .clk    (clk),
        .rst    (rst),
        .txd    (txd),
        .tick   (tick),
        .pop    (pop),
        .empty  (empty),
        .state  (uFsm.state),
        .apbRsp (apbRsp)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int randBelow(input int n);
        rngState = xorshift(rngState);
        return int'(rngState % 32'(n));
    endfunction

    task automatic checkByte(input txByte_t got, input txByte_t exp);
        if (got !== exp) begin
            dataErrs++;
            $display("FAIL %0t: byte 0x%02h on the line, expected 0x%02h", $time, got, exp);
        end
    endtask

    task automatic checkStatus(input uartStatus_t got, input uartStatus_t exp);
        if (got !== exp) begin
            statusErrs++;
            $display("FAIL %0t: STATUS busy=%b full=%b empty=%b level=%0d", $time,
                     got.busy, got.full, got.empty, got.level);
            $display("FAIL %0t: expected busy=%b full=%b empty=%b level=%0d", $time,
                     exp.busy, exp.full, exp.empty, exp.level);
        end
    endtask

    task automatic checkDivisor(input divisor_t got, input divisor_t exp);
        if (got !== exp) begin
            divErrs++;
            $display("FAIL %0t: DIVISOR reads %0d, expected %0d", $time, got, exp);
        end
    endtask

    task automatic checkSlvErr(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            busErrs++;
            $display("FAIL %0t: pslverr %b on %s, expected %b", $time, got, what, exp);
        end
    endtask

    task automatic checkReady(input logic got);
        if (got !== 1'b1) begin
            busErrs++;
            $display("FAIL %0t: pready %b in the access cycle, expected 1", $time, got);
        end
    endtask

    task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data, output logic err);
        @(posedge clk);
        apbReq <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
        @(posedge clk);
        apbReq.penable <= 1'b1;
        @(negedge clk);
        err = apbRsp.pslverr;
        checkReady(apbRsp.pready);
        @(posedge clk);  // Access edge.
        apbReq <= '0;
    endtask

    task automatic apbRead(input logic [7:0] addr, output logic [31:0] data, output logic err);
        @(posedge clk);
        apbReq <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'h0};
        @(posedge clk);
        apbReq.penable <= 1'b1;
        @(negedge clk);
        data = apbRsp.prdata;
        err  = apbRsp.pslverr;
        checkReady(apbRsp.pready);
        @(posedge clk);
        apbReq <= '0;
    endtask

    task automatic sendByte(input txByte_t b);
        logic err;
        logic expErr;
        apbWrite(`UART_ADDR_DATA, {rngState[31:8], b}, err);
        expErr = ((accepted - started) == `UART_FIFO_DEPTH);  // Level before this push.
        checkSlvErr(err, expErr, "DATA write");
        if (!expErr) begin
            expQ.push_back(b);
            accepted++;
        end
    endtask

    task automatic setDivisor(input logic [31:0] value);
        logic        err;
        logic [31:0] rdata;
        apbWrite(`UART_ADDR_DIV, value, err);
        checkSlvErr(err, 1'b0, "DIVISOR write");
        modelDiv = (value < 32'd2) ? divisor_t'(2) : divisor_t'(value);
        apbRead(`UART_ADDR_DIV, rdata, err);
        checkSlvErr(err, 1'b0, "DIVISOR read");
        checkDivisor(divisor_t'(rdata), modelDiv);
    endtask

    task automatic checkModelStatus();
        logic [31:0] rdata;
        logic        err;
        uartStatus_t exp;
        int          lvl;
        lvl       = accepted - started;
        exp.busy  = frameActive;
        exp.full  = (lvl == `UART_FIFO_DEPTH);
        exp.empty = (lvl == 0);
        exp.level = fifoLevel_t'(lvl);
        apbRead(`UART_ADDR_STATUS, rdata, err);
        checkSlvErr(err, 1'b0, "STATUS read");
        checkStatus(uartStatus_t'(rdata[7:0]), exp);
    endtask

    task automatic waitIdle();
        while (expQ.size() != 0 || frameActive) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
    endtask

    // Checks every cycle of the frame plus two idle cycles after the stop bit.
    task automatic decodeFrame();
        int         div;
        int         k;
        txByte_t    expByte;
        txByte_t    gotByte;
        logic [9:0] expFrame;
        div         = int'(modelDiv);
        frameActive = 1'b1;
        started++;
        expByte     = '0;
        if (expQ.size() == 0) begin
            lineErrs++;
            $display("FAIL %0t: a frame started with no byte queued", $time);
        end else begin
            expByte = expQ.pop_front();
        end
        expFrame = {1'b1, expByte, 1'b0};
        gotByte  = '0;
        for (k = 0; k < 10 * div + 2; k++) begin
            @(negedge clk);
            if (txd !== ((k < 10 * div) ? expFrame[k / div] : 1'b1)) begin
                lineErrs++;
                $display("FAIL %0t: txd %b in cycle %0d of a frame, divisor %0d",
                         $time, txd, k, div);
            end
            if ((k % div) == (div / 2) && k / div >= 1 && k / div <= 8) begin
                gotByte[k / div - 1] = txd;  // Mid-bit sample.
            end
        end
        checkByte(gotByte, expByte);
        frameActive = 1'b0;
    endtask

    initial begin : serialModel
        forever begin
            @(negedge txd);
            if (!rst) begin
                decodeFrame();
            end
        end
    end

    initial begin : watchdog
        repeat (BUDGET) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d clock cycles", BUDGET);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin : stimulus
        int          burst;
        int          i;
        int          s0;
        int          total;
        logic        err;
        logic [31:0] rdata;
        rst    <= 1'b1;
        apbReq <= '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        @(negedge clk);

        if (txd !== 1'b1) begin
            lineErrs++;
            $display("FAIL %0t: txd is not high after reset", $time);
        end
        checkModelStatus();
        apbRead(`UART_ADDR_DIV, rdata, err);
        checkDivisor(divisor_t'(rdata), divisor_t'(234));

        for (burst = 0; burst < RAND_BURSTS; burst++) begin
            setDivisor(32'(4 + randBelow(6)));
            for (i = 0; i < BURST_LEN; i++) begin
                sendByte(txByte_t'(randBelow(256)));
                repeat (randBelow(8)) @(posedge clk);
            end
            waitIdle();
            checkModelStatus();
        end

        // Keep the line busy, then overfill the queue.
        setDivisor(32'(FULL_DIV));
        s0 = started;
        sendByte(txByte_t'(randBelow(256)));
        while (started == s0) begin
            @(posedge clk);
        end
        for (i = 0; i < FULL_WRITES; i++) begin
            sendByte(txByte_t'(randBelow(256)));
        end
        checkModelStatus();
        waitIdle();
        checkModelStatus();

        for (burst = 0; burst < 2; burst++) begin
            setDivisor(32'(10 + randBelow(MAX_DIV - 9)));
            sendByte(txByte_t'(randBelow(256)));
            sendByte(txByte_t'(randBelow(256)));
            waitIdle();
        end
        setDivisor(32'd0);
        setDivisor(32'd1);
        sendByte(txByte_t'(randBelow(256)));
        sendByte(txByte_t'(randBelow(256)));
        waitIdle();

        apbRead(8'h0C, rdata, err);
        checkSlvErr(err, 1'b1, "unmapped read");
        apbWrite(8'h10, 32'h5a, err);
        checkSlvErr(err, 1'b1, "unmapped write");
        checkModelStatus();

        total = dataErrs + statusErrs + divErrs + busErrs + lineErrs;
        $display("Errors: data %0d, status %0d, divisor %0d, bus %0d, line %0d",
                 dataErrs, statusErrs, divErrs, busErrs, lineErrs);
        if (total == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* uartTx_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module uartTx_checker (
    input logic              clk,
    input logic              rst,
    input logic              txd,
    input logic              tick,
    input logic              pop,
    input logic              empty,
    input uartPkg::txState_e state,
    input uartPkg::apbRsp_t  apbRsp
);
    import uartPkg::*;

    lineHighWhenIdle: assert property (@(posedge clk) disable iff (rst)
        (state == IDLE || state == GUARD) |-> txd)
        else $error("txd low while the FSM is in IDLE or GUARD");

    tickInsideFrame: assert property (@(posedge clk) disable iff (rst)
        tick |-> (state != IDLE))
        else $error("baud tick seen outside a frame");

    noPopWhenEmpty: assert property (@(posedge clk) disable iff (rst)
        pop |-> !empty)
        else $error("FIFO pop requested while empty");

    // No wait states on the bus.
    readyAlwaysHigh: assert property (@(posedge clk) apbRsp.pready)
        else $error("pready dropped low");

endmodule

`default_nettype wire

/* tbClock.sv */
`timescale 1ns/1ns
`default_nettype none

module tbClock (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;  // 4 ns period.
        end
    end

endmodule

`default_nettype wire

/* uartTx.sv */
`timescale 1ns/1ns
`default_nettype none

module uartTx (
    input  logic             clk,
    input  logic             rst,
    input  uartPkg::apbReq_t apbReq,
    output uartPkg::apbRsp_t apbRsp,
    output logic             txd
);
    import uartPkg::*;

    logic        push;
    txByte_t     pushData;
    logic        pop;
    txByte_t     popData;
    logic        full;
    logic        empty;
    fifoLevel_t  level;
    logic        load;
    logic        shift;
    logic        start;
    logic        tick;
    logic        busy;
    divisor_t    divisor;
    uartStatus_t status;

    assign status = '{busy: busy, full: full, empty: empty, level: level};

    apbUartRegs uRegs (
        .clk      (clk),
        .rst      (rst),
        .apbReq   (apbReq),
        .apbRsp   (apbRsp),
        .status   (status),
        .full     (full),
        .push     (push),
        .pushData (pushData),
        .divisor  (divisor)
    );

    txFifo uFifo (
        .clk      (clk),
        .rst      (rst),
        .push     (push),
        .pushData (pushData),
        .pop      (pop),
        .popData  (popData),
        .full     (full),
        .empty    (empty),
        .level    (level)
    );

    txFsm uFsm (
        .clk   (clk),
        .rst   (rst),
        .empty (empty),
        .tick  (tick),
        .pop   (pop),
        .load  (load),
        .start (start),
        .shift (shift),
        .busy  (busy)
    );

    baudTimer uTimer (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .divisor (divisor),
        .tick    (tick)
    );

    txShifter uShifter (
        .clk      (clk),
        .rst      (rst),
        .load     (load),
        .shift    (shift),
        .loadData (popData),
        .txd      (txd)
    );

endmodule

`default_nettype wire

/* apbUartRegs.sv */
`timescale 1ns/1ns
`default_nettype none
`include "uart_params.svh"

module apbUartRegs (
    input  logic                 clk,
    input  logic                 rst,
    input  uartPkg::apbReq_t     apbReq,
    output uartPkg::apbRsp_t     apbRsp,
    input  uartPkg::uartStatus_t status,
    input  logic                 full,
    output logic                 push,
    output uartPkg::txByte_t     pushData,
    output uartPkg::divisor_t    divisor
);
    import uartPkg::*;

    localparam divisor_t MIN_DIV = divisor_t'(2);

    logic        access;
    logic        isData;
    logic        isStatus;
    logic        isDiv;
    logic        mapped;
    logic        slvErr;
    logic [31:0] rdData;
    divisor_t    wrDiv;

    assign access   = apbReq.psel && apbReq.penable;
    assign isData   = (apbReq.paddr == `UART_ADDR_DATA);
    assign isStatus = (apbReq.paddr == `UART_ADDR_STATUS);
    assign isDiv    = (apbReq.paddr == `UART_ADDR_DIV);
    assign mapped   = isData || isStatus || isDiv;

    // Byte is dropped when the queue is full.
    assign push     = access && apbReq.pwrite && isData && !full;
    assign pushData = apbReq.pwdata[7:0];

    assign wrDiv = divisor_t'(apbReq.pwdata);

    always_ff @(posedge clk) begin
        if (rst) begin
            divisor <= divisor_t'(`UART_DEFAULT_DIV);
        end else if (access && apbReq.pwrite && isDiv) begin
            divisor <= (wrDiv < MIN_DIV) ? MIN_DIV : wrDiv;  // Clamp to 2.
        end
    end

    always_comb begin
        rdData = '0;
        if (access && !apbReq.pwrite) begin
            case (apbReq.paddr)
                `UART_ADDR_STATUS: rdData = 32'(status);
                `UART_ADDR_DIV:    rdData = 32'(divisor);
                default:           rdData = '0;  // DATA reads as zero.
            endcase
        end
    end

    assign slvErr = access && (!mapped || (apbReq.pwrite && isData && full));

    // No wait states.
    assign apbRsp = '{prdata: rdData, pready: 1'b1, pslverr: slvErr};

endmodule

`default_nettype wire

/* txFifo.sv */
`timescale 1ns/1ns
`default_nettype none
`include "uart_params.svh"

module txFifo #(
    parameter int DEPTH = `UART_FIFO_DEPTH
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                push,
    input  uartPkg::txByte_t    pushData,
    input  logic                pop,
    output uartPkg::txByte_t    popData,
    output logic                full,
    output logic                empty,
    output uartPkg::fifoLevel_t level
);
    import uartPkg::*;

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    txByte_t        mem [DEPTH];
    logic [AW-1:0]  wrPtr;
    logic [AW-1:0]  rdPtr;
    fifoLevel_t     count;
    logic           doPush;
    logic           doPop;

    assign doPush = push && !full;
    assign doPop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= pushData;
        end
    end

    // Pointers wrap naturally for power-of-two depths.
    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            if (doPush && !doPop) begin
                count <= count + fifoLevel_t'(1);
            end else if (doPop && !doPush) begin
                count <= count - fifoLevel_t'(1);
            end
        end
    end

    assign popData = mem[rdPtr];  // Head byte, valid with pop.
    assign full    = (count == fifoLevel_t'(DEPTH));
    assign empty   = (count == '0);
    assign level   = count;

endmodule

`default_nettype wire

/* txShifter.sv */
`timescale 1ns/1ns
`default_nettype none

module txShifter (
    input  logic            clk,
    input  logic            rst,
    input  logic            load,
    input  logic            shift,
    input  uartPkg::txByte_t loadData,
    output logic            txd
);
    logic [9:0] frame;

    // Frame is stop, data MSB..LSB, start; sent from bit 0.
    always_ff @(posedge clk) begin
        if (rst) begin
            frame <= '1;
        end else if (load) begin
            frame <= {1'b1, loadData, 1'b0};
        end else if (shift) begin
            frame <= {1'b1, frame[9:1]};  // Fill with idle level.
        end
    end

    // Registered output keeps the line glitch free.
    always_ff @(posedge clk) begin
        if (rst) begin
            txd <= 1'b1;
        end else begin
            txd <= frame[0];
        end
    end

endmodule

`default_nettype wire

/* txFsm.sv */
`timescale 1ns/1ns
`default_nettype none

module txFsm (
    input  logic clk,
    input  logic rst,
    input  logic empty,
    input  logic tick,
    output logic pop,
    output logic load,
    output logic start,
    output logic shift,
    output logic busy
);
    import uartPkg::*;

    txState_e   state;
    txState_e   nextState;
    logic [2:0] bitCnt;  // Data bit index.

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= IDLE;
            bitCnt <= '0;
        end else begin
            state <= nextState;
            if (state == START && tick) begin
                bitCnt <= '0;
            end else if (state == DATA && tick) begin
                bitCnt <= bitCnt + 3'd1;
            end
        end
    end

    always_comb begin
        nextState = state;
        pop       = 1'b0;
        load      = 1'b0;
        start     = 1'b0;
        shift     = 1'b0;
        case (state)
            IDLE: begin
                if (!empty) begin
                    pop       = 1'b1;
                    load      = 1'b1;
                    start     = 1'b1;
                    nextState = START;
                end
            end
            START: begin
                shift = tick;
                if (tick) begin
                    nextState = DATA;
                end
            end
            DATA: begin
                shift = tick;
                if (tick && bitCnt == 3'd7) begin
                    nextState = STOP;
                end
            end
            STOP: begin
                shift = tick;
                if (tick) begin
                    nextState = GUARD;
                end
            end
            GUARD: begin
                nextState = IDLE;  // One cycle of extra line idle.
            end
            default: begin
                nextState = IDLE;
            end
        endcase
    end

    assign busy = (state != IDLE);

endmodule

`default_nettype wire

/* baudTimer.sv */
`timescale 1ns/1ns
`default_nettype none

module baudTimer (
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    input  uartPkg::divisor_t divisor,
    output logic            tick
);
    import uartPkg::*;

    localparam logic [3:0] FRAME_BITS = 4'd10;

    divisor_t   count;
    logic [3:0] bitsLeft;  // Bit periods left in the frame.
    logic       running;

    assign running = (bitsLeft != 4'd0);
    assign tick    = running && (count == '0);  // Last cycle of a bit.

    always_ff @(posedge clk) begin
        if (rst) begin
            count    <= '0;
            bitsLeft <= '0;
        end else if (start) begin
            count    <= divisor - divisor_t'(1);
            bitsLeft <= FRAME_BITS;
        end else if (tick) begin
            count    <= divisor - divisor_t'(1);  // New divisor applies here.
            bitsLeft <= bitsLeft - 4'd1;
        end else if (running) begin
            count    <= count - divisor_t'(1);
        end
    end

endmodule

`default_nettype wire

/* uartPkg.sv */
`default_nettype none

package uartPkg;

    typedef logic [7:0]  txByte_t;
    typedef logic [15:0] divisor_t;    // Clock cycles per bit from 2 up.
    typedef logic [4:0]  fifoLevel_t;  // Covers a depth of up to 16.

    typedef enum logic [2:0] {
        IDLE,
        START,
        DATA,
        STOP,
        GUARD
    } txState_e;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apbReq_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apbRsp_t;

    typedef struct packed {
        logic       busy;
        logic       full;
        logic       empty;
        fifoLevel_t level;
    } uartStatus_t;

endpackage

`default_nettype wire

/* uart_params.svh */
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// Register offsets on the APB side.
`define UART_ADDR_DATA   8'h00
`define UART_ADDR_STATUS 8'h04
`define UART_ADDR_DIV    8'h08

// 27 MHz / 115200 baud.
`define UART_DEFAULT_DIV 16'd234

// Transmit queue depth as a power of two up to 16.
`define UART_FIFO_DEPTH  16

`endif
